// ==== rtl/ahbMemPkg.sv ====
package ahbMemPkg;

  //--------------------------------------------------------------------------
  // Bus and memory geometry
  //--------------------------------------------------------------------------
  localparam int DataWidth    = 32;
  localparam int AddrWidth    = 32;
  localparam int MemDepth     = 256;  // Words
  localparam int MemIdxBits   = 8;
  localparam int ByteAddrBits = 10;   // Byte offset inside the memory

  // Required HPROT[3:1] is non-cacheable, non-bufferable and privileged
  localparam logic [2:0] PROT_REQUIRED = 3'b001;

  //--------------------------------------------------------------------------
  // AHB encodings
  //--------------------------------------------------------------------------
  typedef enum logic [1:0] {
    Idle   = 2'b00,
    Busy   = 2'b01,
    NonSeq = 2'b10,
    Seq    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    Single = 3'b000,
    Incr   = 3'b001,  // Undefined length
    Wrap4  = 3'b010,
    Incr4  = 3'b011,
    Wrap8  = 3'b100,
    Incr8  = 3'b101,
    Wrap16 = 3'b110,
    Incr16 = 3'b111
  } hburst_e;

  typedef enum logic [2:0] {
    SizeByte   = 3'b000,
    SizeHalf   = 3'b001,
    SizeWord   = 3'b010,
    SizeWord2  = 3'b011,  // Everything from here up is wider than the bus
    SizeWord4  = 3'b100,
    SizeWord8  = 3'b101,
    SizeWord16 = 3'b110,
    SizeWord32 = 3'b111
  } hsize_e;

  typedef enum logic {
    RespOkay  = 1'b0,
    RespError = 1'b1
  } hresp_e;

  // Response FSM of the subordinate
  typedef enum logic [1:0] {
    RespIdle = 2'b00,
    RespData = 2'b01,  // OKAY data phase
    RespErr1 = 2'b10,  // ERROR with HREADYout low
    RespErr2 = 2'b11   // ERROR with HREADYout high
  } respState_e;

  //--------------------------------------------------------------------------
  // Internal bundles
  //--------------------------------------------------------------------------

  // Transfer accepted in the address phase and used in the data phase
  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [1:0]              size;      // Byte, half or word only
    logic [ByteAddrBits-1:0] byteAddr;  // Already aligned to size
  } dataPhaseReq_t;

  // Controller to burst address generator
  typedef struct packed {
    logic                    start;     // Accepted NONSEQ
    logic                    advance;   // Accepted SEQ inside a burst
    hburst_e                 burst;
    logic [1:0]              size;
    logic [ByteAddrBits-1:0] byteAddr;  // Address of the current beat
  } beatCtrl_t;

endpackage

// ==== rtl/addrPhaseCtrl.sv ====
`timescale 1ns/1ns

module addrPhaseCtrl
  import ahbMemPkg::*;
(
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  logic                    HSEL,
  input  logic [AddrWidth-1:0]    HADDR,
  input  htrans_e                 HTRANS,
  input  logic                    HWRITE,
  input  hsize_e                  HSIZE,
  input  hburst_e                 HBURST,
  input  logic [3:0]              HPROT,
  input  logic                    HREADYin,
  input  logic [ByteAddrBits-1:0] beatAddr,
  output logic                    HREADYout,
  output hresp_e                  resp,
  output beatCtrl_t               beatCtrl,
  output dataPhaseReq_t           dataReq
);

  respState_e state;
  respState_e nextState;

  logic                    isNonSeq;
  logic                    isSeq;
  logic                    accept;
  logic [AddrWidth-1:0]    selAddr;
  logic [1:0]              sizeSel;
  logic [ByteAddrBits-1:0] alignMask;
  logic [ByteAddrBits-1:0] alignedAddr;
  logic                    protOk;
  logic                    sizeOk;
  logic                    rangeOk;
  logic                    passOk;

  // Data phase request registers
  logic                    reqValidQ;
  logic                    reqWriteQ;
  logic [1:0]              reqSizeQ;
  logic [ByteAddrBits-1:0] reqAddrQ;

  //--------------------------------------------------------------------------
  // Address phase decode and checks
  //--------------------------------------------------------------------------
  assign isNonSeq = (HTRANS == NonSeq);
  assign isSeq    = (HTRANS == Seq);

  // Nothing is sampled while the first ERROR cycle holds HREADYout low
  assign accept = HSEL && HREADYin && (isNonSeq || isSeq) && (state != RespErr1);

  // SEQ beats take the locally tracked address and ignore HADDR
  assign selAddr = isSeq ? {{(AddrWidth-ByteAddrBits){1'b0}}, beatAddr} : HADDR;

  assign sizeSel     = HSIZE[1:0];
  assign alignMask   = ~((ByteAddrBits'(1) << sizeSel) - ByteAddrBits'(1));
  assign alignedAddr = selAddr[ByteAddrBits-1:0] & alignMask;  // Low bits masked

  assign protOk  = (HPROT[3:1] == PROT_REQUIRED);
  assign sizeOk  = (HSIZE <= SizeWord);
  assign rangeOk = (selAddr[AddrWidth-1:2] < (AddrWidth-2)'(MemDepth));
  assign passOk  = protOk && sizeOk && rangeOk;

  //--------------------------------------------------------------------------
  // Burst generator control
  //--------------------------------------------------------------------------
  always_comb begin
    beatCtrl.start    = accept && isNonSeq;
    beatCtrl.advance  = accept && isSeq && (HBURST != Single);
    beatCtrl.burst    = HBURST;
    beatCtrl.size     = sizeSel;
    beatCtrl.byteAddr = alignedAddr;
  end

  //--------------------------------------------------------------------------
  // Response FSM
  //--------------------------------------------------------------------------
  always_comb begin
    nextState = RespIdle;
    if (state == RespErr1) begin
      nextState = RespErr2;  // Second ERROR cycle always follows
    end else if (accept) begin
      nextState = passOk ? RespData : RespErr1;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= RespIdle;
    end else begin
      state <= nextState;
    end
  end

  assign HREADYout = (state != RespErr1);
  assign resp      = ((state == RespErr1) || (state == RespErr2)) ? RespError : RespOkay;

  //--------------------------------------------------------------------------
  // Data phase request register
  //--------------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      reqValidQ <= 1'b0;
    end else begin
      reqValidQ <= accept && passOk;  // Failed transfers never reach memory
    end
  end

  always_ff @(posedge HCLK) begin
    if (accept) begin
      reqWriteQ <= HWRITE;
      reqSizeQ  <= sizeSel;
      reqAddrQ  <= alignedAddr;
    end
  end

  always_comb begin
    dataReq.valid    = reqValidQ;
    dataReq.write    = reqWriteQ;
    dataReq.size     = reqSizeQ;
    dataReq.byteAddr = reqAddrQ;
  end

endmodule

// ==== rtl/burstAddrGen.sv ====
`timescale 1ns/1ns

module burstAddrGen
  import ahbMemPkg::*;
(
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  beatCtrl_t               beatCtrl,
  output logic [ByteAddrBits-1:0] beatAddr
);

  logic [ByteAddrBits-1:0] firstAddr;  // Holds the wrap block base
  hburst_e                 burstQ;
  logic [1:0]              sizeQ;

  // Next beat address for both INCR and WRAP types
  function automatic logic [ByteAddrBits-1:0] stepAddr(
    input logic [ByteAddrBits-1:0] cur,
    input logic [ByteAddrBits-1:0] first,
    input hburst_e                 burst,
    input logic [1:0]              size
  );
    logic [ByteAddrBits-1:0] incAddr;
    logic [ByteAddrBits-1:0] wrapMask;
    logic                    isWrap;
    incAddr = cur + (ByteAddrBits'(1) << size);
    isWrap  = 1'b1;
    case (burst)
      Wrap4:   wrapMask = (ByteAddrBits'(4) << size) - ByteAddrBits'(1);
      Wrap8:   wrapMask = (ByteAddrBits'(8) << size) - ByteAddrBits'(1);
      Wrap16:  wrapMask = (ByteAddrBits'(16) << size) - ByteAddrBits'(1);
      default: begin
        wrapMask = '0;
        isWrap   = 1'b0;
      end
    endcase
    // Upper bits come from the first beat and lower bits count modulo the block
    if (isWrap) begin
      stepAddr = (first & ~wrapMask) | (incAddr & wrapMask);
    end else begin
      stepAddr = incAddr;
    end
  endfunction

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      firstAddr <= '0;
      burstQ    <= Single;
      sizeQ     <= '0;
      beatAddr  <= '0;
    end else if (beatCtrl.start) begin
      firstAddr <= beatCtrl.byteAddr;
      burstQ    <= beatCtrl.burst;
      sizeQ     <= beatCtrl.size;
      beatAddr  <= stepAddr(beatCtrl.byteAddr, beatCtrl.byteAddr,
                            beatCtrl.burst, beatCtrl.size);
    end else if (beatCtrl.advance) begin
      beatAddr  <= stepAddr(beatAddr, firstAddr, burstQ, sizeQ);
    end
    // BUSY and IDLE leave the beat address where it is
  end

endmodule

// ==== rtl/byteLaneMem.sv ====
`timescale 1ns/1ns

module byteLaneMem
  import ahbMemPkg::*;
(
  input  logic                 HCLK,
  input  dataPhaseReq_t        dataReq,
  input  logic [DataWidth-1:0] HWDATA,
  output logic [DataWidth-1:0] HRDATA
);

  logic [DataWidth-1:0]   mem [MemDepth];
  logic [MemIdxBits-1:0]  wordIdx;
  logic [DataWidth/8-1:0] laneEn;

  assign wordIdx = dataReq.byteAddr[ByteAddrBits-1:2];

  //--------------------------------------------------------------------------
  // Byte lane decode from size and low address bits
  //--------------------------------------------------------------------------
  always_comb begin
    case (dataReq.size)
      2'd0:    laneEn = 4'b0001 << dataReq.byteAddr[1:0];
      2'd1:    laneEn = 4'b0011 << {dataReq.byteAddr[1], 1'b0};
      default: laneEn = 4'b1111;  // Word
    endcase
  end

  // Write data arrives in the data phase and lands at its closing edge
  always_ff @(posedge HCLK) begin
    if (dataReq.valid && dataReq.write) begin
      for (int lane = 0; lane < DataWidth/8; lane++) begin
        if (laneEn[lane]) begin
          mem[wordIdx][lane*8 +: 8] <= HWDATA[lane*8 +: 8];
        end
      end
    end
  end

  // Whole word on the bus including unselected lanes
  assign HRDATA = mem[wordIdx];

endmodule

// ==== rtl/ahbSubordinate.sv ====
`timescale 1ns/1ns

module ahbSubordinate
  import ahbMemPkg::*;
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic                 HSEL,
  input  logic [AddrWidth-1:0] HADDR,
  input  logic [1:0]           HTRANS,
  input  logic                 HWRITE,
  input  logic [2:0]           HSIZE,
  input  logic [2:0]           HBURST,
  input  logic [3:0]           HPROT,
  input  logic [DataWidth-1:0] HWDATA,
  input  logic                 HREADYin,
  output logic [DataWidth-1:0] HRDATA,
  output logic [1:0]           HRESP,
  output logic                 HREADYout
);

  beatCtrl_t               beatCtrl;
  dataPhaseReq_t           dataReq;
  logic [ByteAddrBits-1:0] beatAddr;
  hresp_e                  resp;

  assign HRESP = {1'b0, resp};  // Only OKAY and ERROR are ever given

  addrPhaseCtrl addrPhaseCtrl_i (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HTRANS    (htrans_e'(HTRANS)),
    .HWRITE    (HWRITE),
    .HSIZE     (hsize_e'(HSIZE)),
    .HBURST    (hburst_e'(HBURST)),
    .HPROT     (HPROT),
    .HREADYin  (HREADYin),
    .beatAddr  (beatAddr),
    .HREADYout (HREADYout),
    .resp      (resp),
    .beatCtrl  (beatCtrl),
    .dataReq   (dataReq)
  );

  burstAddrGen burstAddrGen_i (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .beatCtrl (beatCtrl),
    .beatAddr (beatAddr)
  );

  byteLaneMem byteLaneMem_i (
    .HCLK    (HCLK),
    .dataReq (dataReq),
    .HWDATA  (HWDATA),
    .HRDATA  (HRDATA)
  );

endmodule

// ==== dv/ahbBusTasks.svh ====
// Address phase of a new transfer and data phase of the last one in one bus cycle
task automatic busCycle(input htrans_e trans, input logic [31:0] addr,
                        input logic [31:0] busAddr, input logic write, input hsize_e size,
                        input hburst_e burst, input logic [3:0] prot,
                        input logic [31:0] wdata);
  int         bytes;
  logic [9:0] aligned;
  logic       isErr;
  bytes   = 1 << int'(size);
  aligned = addr[9:0] & ~10'(bytes - 1);  // Low bits below the size are dropped
  isErr   = (prot[3:1] != PROT_REQUIRED) || (size > SizeWord) ||
            (addr >= 32'(MemDepth * 4));

  expReady = (pendKind != PendErr1);
  expResp  = (pendKind == PendErr1 || pendKind == PendErr2) ? 2'b01 : 2'b00;
  expRead  = 1'b0;
  if (pendKind == PendOkay && pendWrite) begin
    HWDATA = pendData;
    modelWrite(pendAddr, pendBytes, pendData);
  end else begin
    HWDATA = $random(seed);  // Junk outside write data phases
    if (pendKind == PendOkay) begin
      expectRead(pendAddr);
    end
  end

  HSEL   = 1'b1;
  HADDR  = busAddr;
  HTRANS = trans;
  HWRITE = write;
  HSIZE  = size;
  HBURST = burst;
  HPROT  = prot;

  if (pendKind == PendErr1) begin
    pendKind = PendErr2;  // Transfer shown here is ignored by the DUT
  end else if (trans == NonSeq || trans == Seq) begin
    pendKind = isErr ? PendErr1 : PendOkay;
  end else begin
    pendKind = PendNone;
  end
  pendWrite = write;
  pendAddr  = aligned;
  pendBytes = bytes;
  pendData  = wdata;
  @(posedge HCLK);
  #DriveDelay;
endtask

task automatic idleCycles(input int count);
  repeat (count) begin
    busCycle(Idle, 32'h0, 32'h0, 1'b0, SizeWord, Single, GoodProt, 32'h0);
  end
endtask

task automatic singleWrite(input logic [31:0] addr, input hsize_e size,
                           input logic [31:0] data);
  busCycle(NonSeq, addr, addr, 1'b1, size, Single, GoodProt, data);
endtask

task automatic singleRead(input logic [31:0] addr, input hsize_e size);
  busCycle(NonSeq, addr, addr, 1'b0, size, Single, GoodProt, 32'h0);
endtask

// Write burst with an optional BUSY before beat busyAt
task automatic burstWrite(input hburst_e burst, input hsize_e size, input logic [9:0] start,
                          input int beats, input int busyAt, input logic corrupt);
  logic [9:0]  addr;
  logic [31:0] busAddr;
  addr = start;
  for (int i = 0; i < beats; i++) begin
    if (i == busyAt) begin
      busCycle(Busy, 32'(addr), 32'(addr), 1'b1, size, burst, GoodProt, 32'h0);
    end
    busAddr = (corrupt && (i % 2 == 1)) ? 32'(addr ^ 10'h2c0) : 32'(addr);
    busCycle((i == 0) ? NonSeq : Seq, 32'(addr), busAddr, 1'b1, size, burst, GoodProt,
             $random(seed));
    addr = nextBeat(addr, start, burst, 1 << int'(size));
  end
endtask

// Failing write followed by both ERROR cycles
task automatic errorTransfer(input logic [31:0] addr, input hsize_e size,
                             input logic [3:0] prot);
  busCycle(NonSeq, addr, addr, 1'b1, size, Single, prot, 32'hdead_beef);
  // Write shown during the first ERROR cycle must be dropped
  busCycle(NonSeq, 32'h100, 32'h100, 1'b1, SizeWord, Single, GoodProt, 32'h0bad_f00d);
  idleCycles(1);
endtask

// ==== dv/ahbSubordinateTb.sv ====
`timescale 1ns/1ns

module ahbSubordinateTb
  import ahbMemPkg::*;
();

  localparam int ClkPeriod  = 100;
  localparam int DriveDelay = 10;
  // Reset and idle 4, singles 37, INCR 19, WRAP 23, errors 12, tail 2
  localparam int TestCycles    = 4 + 37 + 19 + 23 + 12 + 2;
  localparam int TimeoutCycles = 2 * TestCycles;
  localparam logic [3:0] GoodProt = {PROT_REQUIRED, 1'b1};

  // Data phase bookkeeping of the transfer from the previous cycle
  localparam int PendNone = 0;
  localparam int PendOkay = 1;
  localparam int PendErr1 = 2;
  localparam int PendErr2 = 3;

  logic                 HCLK;
  logic                 HRESETn;
  logic                 HSEL;
  logic [AddrWidth-1:0] HADDR;
  logic [1:0]           HTRANS;
  logic                 HWRITE;
  logic [2:0]           HSIZE;
  logic [2:0]           HBURST;
  logic [3:0]           HPROT;
  logic [DataWidth-1:0] HWDATA;
  logic                 HREADYin;
  logic [DataWidth-1:0] HRDATA;
  logic [1:0]           HRESP;
  logic                 HREADYout;

  // Reference memory with one byte per entry and a written flag
  logic [7:0] modelMem [MemDepth*4];
  logic       modelKnown [MemDepth*4];

  // Expected response of the current data phase
  logic        expReady;
  logic [1:0]  expResp;
  logic        expRead;
  logic [31:0] expData;
  logic [31:0] expMask;  // Lanes never written are not compared

  int          pendKind;
  logic        pendWrite;
  logic [9:0]  pendAddr;
  int          pendBytes;
  logic [31:0] pendData;

  int     readyErrors = 0;
  int     respErrors  = 0;
  int     dataErrors  = 0;
  int     cycleCount  = 0;
  integer seed;

  ahbSubordinate ahbSubordinate_i (.*);

  initial begin
    HCLK = 1'b0;
    forever begin
      #(ClkPeriod/2) HCLK = ~HCLK;
    end
  end

  //--------------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------------
  task automatic modelWrite(input logic [9:0] addr, input int bytes, input logic [31:0] data);
    int idx;
    for (int i = 0; i < bytes; i++) begin
      idx = int'(addr) + i;
      modelMem[idx]   = data[(idx % 4)*8 +: 8];  // Lane follows the byte address
      modelKnown[idx] = 1'b1;
    end
  endtask

  task automatic expectRead(input logic [9:0] addr);
    int base;
    base = int'(addr) & ~3;
    for (int lane = 0; lane < 4; lane++) begin
      expData[lane*8 +: 8] = modelMem[base + lane];
      expMask[lane*8 +: 8] = modelKnown[base + lane] ? 8'hff : 8'h00;
    end
    expRead = 1'b1;
  endtask

  // Next beat address by the INCR and WRAP rules
  function automatic logic [9:0] nextBeat(input logic [9:0] cur, input logic [9:0] first,
                                          input hburst_e burst, input int bytes);
    int span;
    int base;
    case (burst)
      Wrap4:   span = 4 * bytes;
      Wrap8:   span = 8 * bytes;
      Wrap16:  span = 16 * bytes;
      default: span = 0;
    endcase
    if (span == 0) begin
      return cur + 10'(bytes);
    end
    base = int'(first) - (int'(first) % span);  // Block base stays fixed
    return 10'(base + ((int'(cur) - base + bytes) % span));
  endfunction

  `include "ahbBusTasks.svh"

  //--------------------------------------------------------------------------
  // Checks at the DUT ports
  //--------------------------------------------------------------------------
  readyCheck: assert property (@(posedge HCLK) disable iff (!HRESETn)
                               HREADYout == expReady)
    else begin
      readyErrors++;
      $display("CHECK FAILED HREADYout: got %h, expected %h",
               $sampled(HREADYout), $sampled(expReady));
    end

  respCheck: assert property (@(posedge HCLK) disable iff (!HRESETn) HRESP == expResp)
    else begin
      respErrors++;
      $display("CHECK FAILED HRESP: got %h, expected %h", $sampled(HRESP), $sampled(expResp));
    end

  dataCheck: assert property (@(posedge HCLK) disable iff (!HRESETn)
                              !expRead || ((HRDATA & expMask) == (expData & expMask)))
    else begin
      dataErrors++;
      $display("CHECK FAILED HRDATA: got %h, expected %h (mask %h)",
               $sampled(HRDATA), $sampled(expData), $sampled(expMask));
    end

  always @(posedge HCLK) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------
  initial begin
    logic [9:0] addr;
    hsize_e     size;
    seed     = 32'h3adf65c2;
    HRESETn  = 1'b0;
    HSEL     = 1'b0;
    HADDR    = '0;
    HTRANS   = Idle;
    HWRITE   = 1'b0;
    HSIZE    = SizeWord;
    HBURST   = Single;
    HPROT    = GoodProt;
    HWDATA   = '0;
    HREADYin = 1'b1;  // Only subordinate on the bus
    expReady = 1'b1;
    expResp  = 2'b00;
    expRead  = 1'b0;
    expData  = '0;
    expMask  = '0;
    pendKind = PendNone;
    for (int i = 0; i < MemDepth*4; i++) begin
      modelKnown[i] = 1'b0;
    end
    repeat (2) @(posedge HCLK);
    #DriveDelay;
    HRESETn = 1'b1;

    idleCycles(2);  // Response right after reset

    for (int i = 0; i < 12; i++) begin
      size = hsize_e'(i % 3);
      addr = 10'($random(seed));
      // Whole word first so the unselected lanes hold known data
      singleWrite(32'(addr & ~10'h3), SizeWord, $random(seed));
      singleWrite(32'(addr), size, $random(seed));
      singleRead(32'(addr), size);
    end
    idleCycles(1);

    // INCR bursts with a bogus HADDR on odd SEQ beats
    burstWrite(Incr4, SizeWord, 10'h100, 4, -1, 1'b1);
    burstWrite(Incr, SizeHalf, 10'h212, 6, -1, 1'b1);
    idleCycles(1);
    for (int i = 0; i < 4; i++) begin
      singleRead(32'h100 + 32'(i*4), SizeWord);
      singleRead(32'h210 + 32'(i*4), SizeWord);
    end

    // WRAP bursts from mid-block with a BUSY
    burstWrite(Wrap4, SizeWord, 10'h308, 4, 2, 1'b0);
    burstWrite(Wrap8, SizeHalf, 10'h1a6, 8, 3, 1'b0);
    idleCycles(1);
    for (int i = 0; i < 4; i++) begin
      singleRead(32'h300 + 32'(i*4), SizeWord);
      singleRead(32'h1a0 + 32'(i*4), SizeWord);
    end

    errorTransfer(32'h100, SizeWord, 4'b1011);   // Cacheable
    singleRead(32'h100, SizeWord);
    errorTransfer(32'h104, SizeWord2, GoodProt);
    singleRead(32'h104, SizeWord);
    errorTransfer(32'h508, SizeWord, GoodProt);  // Aliases 0x108 if range is ignored
    singleRead(32'h108, SizeWord);
    idleCycles(2);

    $display("Errors: HREADYout %0d, HRESP %0d, HRDATA %0d",
             readyErrors, respErrors, dataErrors);
    if (readyErrors + respErrors + dataErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+dv
rtl/ahbMemPkg.sv
rtl/addrPhaseCtrl.sv
rtl/burstAddrGen.sv
rtl/byteLaneMem.sv
rtl/ahbSubordinate.sv
dv/ahbSubordinateTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ahbSubordinateTb \
  -f sources.f -o simv \
  && ./obj_dir/simv > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null
test -f sim.log \
  && ! grep -q ">>> FAIL" sim.log \
  || { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
